// ==== hw/alu_ops_pkg.sv ====
`default_nettype none

package alu_ops_pkg;

    // --------------------
    // Packet field widths
    // --------------------
    localparam int DATA_W   = 32;
    localparam int SEQ_W    = 8;
    localparam int DEST_W   = 4;
    localparam int COUNT_W  = 16;

    // Stored packet is {a, b, seq, last}
    localparam int PKT_W    = 2 * DATA_W + SEQ_W + 1;

    // --------------------
    // Operation codes
    // --------------------
    localparam int ALU_OP_W = 3;

    localparam logic [ALU_OP_W-1:0] ALU_NOP = 3'd0;
    localparam logic [ALU_OP_W-1:0] ALU_ADD = 3'd1;
    localparam logic [ALU_OP_W-1:0] ALU_SUB = 3'd2;
    localparam logic [ALU_OP_W-1:0] ALU_MUL = 3'd3;
    localparam logic [ALU_OP_W-1:0] ALU_MAX = 3'd4;
    localparam logic [ALU_OP_W-1:0] ALU_ACC = 3'd5;

    // Default buffering and downstream credits
    localparam int DEFAULT_IN_DEPTH    = 8;
    localparam int DEFAULT_OUT_DEPTH   = 8;
    localparam int DEFAULT_OUT_CREDITS = 4;

endpackage : alu_ops_pkg

`default_nettype wire

// ==== hw/alu_ops_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_ops_fifo #(
    parameter int DEPTH = 8,
    parameter int WIDTH = 8
) (
    input  logic                         ap_clk,
    input  logic                         areset_generator,
    input  logic                         push,
    input  logic [WIDTH-1:0]             din,
    input  logic                         pop,
    output logic [WIDTH-1:0]             dout,
    output logic                         empty,
    output logic [$clog2(DEPTH+1)-1:0]   count
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;

    assign empty = (count == '0);

    // Pointers wrap at DEPTH, so any depth works
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage and registered read port
    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
        if (pop) begin
            dout <= mem[rd_ptr];
        end
    end

endmodule : alu_ops_fifo

`default_nettype wire

// ==== hw/alu_ops_control.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_ops_control #(
    parameter int OUT_DEPTH = 8
) (
    input  logic                                ap_clk,
    input  logic                                areset_generator,
    input  logic                                start,
    input  logic [alu_ops_pkg::ALU_OP_W-1:0]    cfg_op,
    input  logic [alu_ops_pkg::DEST_W-1:0]      cfg_dest,
    input  logic [alu_ops_pkg::COUNT_W-1:0]     cfg_count,
    input  logic                                in_empty,
    input  logic [$clog2(OUT_DEPTH+1)-1:0]      out_count,
    input  logic [1:0]                          kernel_inflight,
    input  logic                                egress_idle,
    output logic                                in_pop,
    output logic                                data_valid,
    output logic [alu_ops_pkg::ALU_OP_W-1:0]    op,
    output logic [alu_ops_pkg::DEST_W-1:0]      dest,
    output logic                                acc_clear,
    output logic                                busy,
    output logic                                done
);

    import alu_ops_pkg::*;

    localparam int OCW = $clog2(OUT_DEPTH + 1);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_RUN   = 2'd1;
    localparam logic [1:0] ST_DRAIN = 2'd2;
    localparam logic [1:0] ST_DONE  = 2'd3;

    logic [1:0]         state;
    logic [COUNT_W-1:0] remaining;
    logic [OCW+1:0]     occupancy;
    logic               pipe_empty;

    // --------------------
    // Admission control
    // --------------------
    // Output slots already claimed: queued results, kernel stages and
    // the packet being read out of the input FIFO this cycle
    assign occupancy = out_count + kernel_inflight + data_valid;

    assign in_pop = (state == ST_RUN) && !in_empty && (remaining != '0)
                    && (occupancy < OUT_DEPTH);

    assign pipe_empty = !data_valid && (kernel_inflight == 2'd0)
                        && (out_count == '0) && egress_idle;

    assign busy = (state != ST_IDLE);
    assign done = (state == ST_DONE);

    // --------------------
    // Job state machine
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state      <= ST_IDLE;
            remaining  <= '0;
            data_valid <= 1'b0;
            acc_clear  <= 1'b0;
        end else begin
            // FIFO read data shows up one cycle after the pop
            data_valid <= in_pop;
            acc_clear  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state     <= ST_RUN;
                        remaining <= cfg_count;
                        acc_clear <= 1'b1;
                    end
                end
                ST_RUN: begin
                    if (in_pop) begin
                        remaining <= remaining - 1'b1;
                    end
                    if ((remaining == '0) || (in_pop && remaining == COUNT_W'(1))) begin
                        state <= ST_DRAIN;
                    end
                end
                ST_DRAIN: begin
                    if (pipe_empty) begin
                        state <= ST_DONE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Job configuration, held for the whole job
    always_ff @(posedge ap_clk) begin
        if (state == ST_IDLE && start) begin
            op   <= cfg_op;
            dest <= cfg_dest;
        end
    end

endmodule : alu_ops_control

`default_nettype wire

// ==== hw/alu_ops_kernel.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_ops_kernel (
    input  logic                                ap_clk,
    input  logic                                areset_generator,
    input  logic                                data_valid,
    input  logic [alu_ops_pkg::DATA_W-1:0]      in_a,
    input  logic [alu_ops_pkg::DATA_W-1:0]      in_b,
    input  logic [alu_ops_pkg::SEQ_W-1:0]       in_seq,
    input  logic                                in_last,
    input  logic [alu_ops_pkg::ALU_OP_W-1:0]    op,
    input  logic                                acc_clear,
    output logic                                result_valid,
    output logic [alu_ops_pkg::DATA_W-1:0]      res_a,
    output logic [alu_ops_pkg::DATA_W-1:0]      res_b,
    output logic [alu_ops_pkg::SEQ_W-1:0]       res_seq,
    output logic                                res_last,
    output logic [1:0]                          inflight
);

    import alu_ops_pkg::*;

    logic              s1_valid;
    logic [DATA_W-1:0] s1_a;
    logic [DATA_W-1:0] s1_b;
    logic [SEQ_W-1:0]  s1_seq;
    logic              s1_last;

    logic [DATA_W-1:0] acc;
    logic [DATA_W-1:0] acc_sum;
    logic [DATA_W-1:0] alu_out;
    logic              is_acc;

    assign is_acc   = (op == ALU_ACC);
    assign acc_sum  = acc + s1_a;
    assign inflight = {1'b0, s1_valid} + {1'b0, result_valid};

    // --------------------
    // Stage 2 datapath
    // --------------------
    always_comb begin
        case (op)
            ALU_NOP: alu_out = s1_a;
            ALU_ADD: alu_out = s1_a + s1_b;
            ALU_SUB: alu_out = s1_a - s1_b;
            // Only the low DATA_W bits of the product are kept
            ALU_MUL: alu_out = s1_a * s1_b;
            ALU_MAX: alu_out = (s1_a > s1_b) ? s1_a : s1_b;
            ALU_ACC: alu_out = acc_sum;
            default: alu_out = s1_a;
        endcase
    end

    // Valid pipe and accumulator
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            s1_valid     <= 1'b0;
            result_valid <= 1'b0;
            acc          <= '0;
        end else begin
            s1_valid     <= data_valid;
            // ACC emits only on the last packet of a sequence
            result_valid <= s1_valid && (!is_acc || s1_last);
            if (acc_clear) begin
                acc <= '0;
            end else if (s1_valid && is_acc) begin
                acc <= s1_last ? '0 : acc_sum;
            end
        end
    end

    // Operand and result registers
    always_ff @(posedge ap_clk) begin
        if (data_valid) begin
            s1_a    <= in_a;
            s1_b    <= in_b;
            s1_seq  <= in_seq;
            s1_last <= in_last;
        end
        if (s1_valid) begin
            res_a    <= alu_out;
            res_b    <= is_acc ? '0 : s1_b;
            res_seq  <= s1_seq;
            res_last <= s1_last;
        end
    end

endmodule : alu_ops_kernel

`default_nettype wire

// ==== hw/alu_ops_egress.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_ops_egress #(
    parameter int OUT_CREDITS = 4
) (
    input  logic                            ap_clk,
    input  logic                            areset_generator,
    input  logic                            out_empty,
    input  logic [alu_ops_pkg::PKT_W-1:0]   fifo_dout,
    input  logic [alu_ops_pkg::DEST_W-1:0]  dest,
    input  logic                            out_credit,
    output logic                            out_pop,
    output logic                            out_valid,
    output logic [alu_ops_pkg::DATA_W-1:0]  out_a,
    output logic [alu_ops_pkg::DATA_W-1:0]  out_b,
    output logic [alu_ops_pkg::SEQ_W-1:0]   out_seq,
    output logic [alu_ops_pkg::DEST_W-1:0]  out_dest,
    output logic                            idle
);

    import alu_ops_pkg::*;

    localparam int CW = $clog2(OUT_CREDITS + 1);

    logic [CW-1:0] credits;

    assign out_pop = !out_empty && (credits != '0);
    assign idle    = !out_valid;

    // FIFO read register holds the popped packet during out_valid
    assign out_a   = fifo_dout[PKT_W-1 -: DATA_W];
    assign out_b   = fifo_dout[PKT_W-1-DATA_W -: DATA_W];
    assign out_seq = fifo_dout[SEQ_W:1];

    // Spend on pop, refill on returned credit
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            credits   <= CW'(OUT_CREDITS);
            out_valid <= 1'b0;
        end else begin
            out_valid <= out_pop;
            if (out_pop && !out_credit) begin
                credits <= credits - 1'b1;
            end else if (!out_pop && out_credit) begin
                credits <= credits + 1'b1;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (out_pop) begin
            out_dest <= dest;
        end
    end

endmodule : alu_ops_egress

`default_nettype wire

// ==== hw/alu_ops_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_ops_top #(
    parameter int IN_DEPTH    = alu_ops_pkg::DEFAULT_IN_DEPTH,
    parameter int OUT_DEPTH   = alu_ops_pkg::DEFAULT_OUT_DEPTH,
    parameter int OUT_CREDITS = alu_ops_pkg::DEFAULT_OUT_CREDITS
) (
    input  logic                                ap_clk,
    input  logic                                areset_generator,
    input  logic                                start,
    input  logic [alu_ops_pkg::ALU_OP_W-1:0]    cfg_op,
    input  logic [alu_ops_pkg::DEST_W-1:0]      cfg_dest,
    input  logic [alu_ops_pkg::COUNT_W-1:0]     cfg_count,
    input  logic                                in_valid,
    input  logic [alu_ops_pkg::DATA_W-1:0]      in_a,
    input  logic [alu_ops_pkg::DATA_W-1:0]      in_b,
    input  logic [alu_ops_pkg::SEQ_W-1:0]       in_seq,
    input  logic                                in_last,
    input  logic                                out_credit,
    output logic                                in_credit,
    output logic                                out_valid,
    output logic [alu_ops_pkg::DATA_W-1:0]      out_a,
    output logic [alu_ops_pkg::DATA_W-1:0]      out_b,
    output logic [alu_ops_pkg::SEQ_W-1:0]       out_seq,
    output logic [alu_ops_pkg::DEST_W-1:0]      out_dest,
    output logic                                busy,
    output logic                                done
);

    import alu_ops_pkg::*;

    logic [PKT_W-1:0]                 in_dout;
    logic                             in_empty;
    logic                             data_valid;
    logic [ALU_OP_W-1:0]              op;
    logic [DEST_W-1:0]                dest;
    logic                             acc_clear;
    logic                             result_valid;
    logic [DATA_W-1:0]                res_a;
    logic [DATA_W-1:0]                res_b;
    logic [SEQ_W-1:0]                 res_seq;
    logic                             res_last;
    logic [1:0]                       kernel_inflight;
    logic [PKT_W-1:0]                 out_dout;
    logic                             out_empty;
    logic [$clog2(OUT_DEPTH+1)-1:0]   out_count;
    logic                             out_pop;
    logic                             egress_idle;

    // --------------------
    // Input side
    // --------------------
    // Each pop hands one credit back upstream
    alu_ops_fifo #(.DEPTH(IN_DEPTH), .WIDTH(PKT_W)) u_in_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (in_valid),
        .din              ({in_a, in_b, in_seq, in_last}),
        .pop              (in_credit),
        .dout             (in_dout),
        .empty            (in_empty),
        .count            ()
    );

    alu_ops_control #(.OUT_DEPTH(OUT_DEPTH)) u_control (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .start            (start),
        .cfg_op           (cfg_op),
        .cfg_dest         (cfg_dest),
        .cfg_count        (cfg_count),
        .in_empty         (in_empty),
        .out_count        (out_count),
        .kernel_inflight  (kernel_inflight),
        .egress_idle      (egress_idle),
        .in_pop           (in_credit),
        .data_valid       (data_valid),
        .op               (op),
        .dest             (dest),
        .acc_clear        (acc_clear),
        .busy             (busy),
        .done             (done)
    );

    alu_ops_kernel u_kernel (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .data_valid       (data_valid),
        .in_a             (in_dout[PKT_W-1 -: DATA_W]),
        .in_b             (in_dout[PKT_W-1-DATA_W -: DATA_W]),
        .in_seq           (in_dout[SEQ_W:1]),
        .in_last          (in_dout[0]),
        .op               (op),
        .acc_clear        (acc_clear),
        .result_valid     (result_valid),
        .res_a            (res_a),
        .res_b            (res_b),
        .res_seq          (res_seq),
        .res_last         (res_last),
        .inflight         (kernel_inflight)
    );

    // --------------------
    // Output side
    // --------------------
    alu_ops_fifo #(.DEPTH(OUT_DEPTH), .WIDTH(PKT_W)) u_out_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (result_valid),
        .din              ({res_a, res_b, res_seq, res_last}),
        .pop              (out_pop),
        .dout             (out_dout),
        .empty            (out_empty),
        .count            (out_count)
    );

    alu_ops_egress #(.OUT_CREDITS(OUT_CREDITS)) u_egress (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .out_empty        (out_empty),
        .fifo_dout        (out_dout),
        .dest             (dest),
        .out_credit       (out_credit),
        .out_pop          (out_pop),
        .out_valid        (out_valid),
        .out_a            (out_a),
        .out_b            (out_b),
        .out_seq          (out_seq),
        .out_dest         (out_dest),
        .idle             (egress_idle)
    );

endmodule : alu_ops_top

`default_nettype wire

// ==== verif/alu_ops_tb_ref.svh ====
`ifndef ALU_OPS_TB_REF_SVH
`define ALU_OPS_TB_REF_SVH

// Expected output for one packet, packed as {emit, res_a, res_b}
function automatic logic [2*DATA_W:0] expected_result(
    input logic [ALU_OP_W-1:0] op_sel,
    input logic [DATA_W-1:0]   a,
    input logic [DATA_W-1:0]   b,
    input logic                last,
    input logic [DATA_W-1:0]   run_sum
);
    logic [2*DATA_W-1:0] product;
    logic [DATA_W-1:0]   res_a;
    logic [DATA_W-1:0]   res_b;
    logic                emit;
    product = {{DATA_W{1'b0}}, a} * {{DATA_W{1'b0}}, b};
    emit    = 1'b1;
    res_b   = b;
    case (op_sel)
        ALU_ADD: res_a = a + b;
        ALU_SUB: res_a = a - b;
        ALU_MUL: res_a = product[DATA_W-1:0];
        ALU_MAX: res_a = (a >= b) ? a : b;
        ALU_ACC: begin
            // Running sum is emitted only on the last packet
            res_a = run_sum + a;
            res_b = '0;
            emit  = last;
        end
        default: res_a = a;
    endcase
    return {emit, res_a, res_b};
endfunction

// 32-bit LCG step
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

`endif

// ==== verif/alu_ops_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_ops_tb;

    import alu_ops_pkg::*;

    `include "alu_ops_tb_ref.svh"

    localparam int CLK_PERIOD      = 40;
    localparam int TOTAL_PKTS      = 5 * 20 + 2 * 20 + 30;
    localparam int WATCHDOG_CYCLES = TOTAL_PKTS * 40 + 2000;
    localparam int EXP_W           = 2 * DATA_W + SEQ_W;

    logic                ap_clk = 1'b0;
    logic                areset_generator;
    logic                start;
    logic [ALU_OP_W-1:0] cfg_op;
    logic [DEST_W-1:0]   cfg_dest;
    logic [COUNT_W-1:0]  cfg_count;
    logic                in_valid;
    logic [DATA_W-1:0]   in_a;
    logic [DATA_W-1:0]   in_b;
    logic [SEQ_W-1:0]    in_seq;
    logic                in_last;
    logic                out_credit;
    logic                in_credit;
    logic                out_valid;
    logic [DATA_W-1:0]   out_a;
    logic [DATA_W-1:0]   out_b;
    logic [SEQ_W-1:0]    out_seq;
    logic [DEST_W-1:0]   out_dest;
    logic                busy;
    logic                done;

    logic [EXP_W-1:0]    exp_q[$];
    logic [31:0]         data_seed   = 32'd27;
    logic [31:0]         credit_seed = 32'd27;
    logic [DEST_W-1:0]   job_dest    = '0;
    logic                bp_hold     = 1'b0;
    int errors, checks, tests_run, jobs_run, done_seen;
    int in_credit_seen, sent_total, valid_total, returned_total, cycle_cnt;

    always #(CLK_PERIOD / 2) ap_clk = ~ap_clk;

    alu_ops_top u_dut (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .start            (start),
        .cfg_op           (cfg_op),
        .cfg_dest         (cfg_dest),
        .cfg_count        (cfg_count),
        .in_valid         (in_valid),
        .in_a             (in_a),
        .in_b             (in_b),
        .in_seq           (in_seq),
        .in_last          (in_last),
        .out_credit       (out_credit),
        .in_credit        (in_credit),
        .out_valid        (out_valid),
        .out_a            (out_a),
        .out_b            (out_b),
        .out_seq          (out_seq),
        .out_dest         (out_dest),
        .busy             (busy),
        .done             (done)
    );

    task automatic compare_field(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] got_v);
        checks++;
        if (got_v !== exp_v) begin
            errors++;
            $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp_v, got_v);
        end
    endtask

    task automatic draw_random(output logic [31:0] value);
        data_seed = lcg_next(data_seed);
        value = data_seed;
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        $display("[%0t ns] %-14s %0d errors", $time, name, errors - err_before);
    endtask

    // --------------------
    // Pulse counters
    // --------------------
    always @(posedge ap_clk) begin
        if (!areset_generator) begin
            if (in_credit) begin
                in_credit_seen <= in_credit_seen + 1;
            end
            if (done) begin
                done_seen <= done_seen + 1;
            end
        end
    end

    // Output compare and downstream credit return
    always @(posedge ap_clk) begin : compare_outputs
        logic [EXP_W-1:0] exp_pkt;
        logic             give;
        if (areset_generator) begin
            out_credit <= 1'b0;
        end else begin
            cycle_cnt++;
            if (out_valid) begin
                valid_total++;
                checks++;
                if (valid_total > DEFAULT_OUT_CREDITS + returned_total) begin
                    errors++;
                    $display("At %0t ns out_valid was sent without a credit", $time);
                end
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("At %0t ns out_valid arrived with no packet expected", $time);
                end else begin
                    exp_pkt = exp_q.pop_front();
                    compare_field("out_a", exp_pkt[EXP_W-1 -: DATA_W], out_a);
                    compare_field("out_b", exp_pkt[EXP_W-1-DATA_W -: DATA_W], out_b);
                    compare_field("out_seq", 32'(exp_pkt[SEQ_W-1:0]), 32'(out_seq));
                    compare_field("out_dest", 32'(job_dest), 32'(out_dest));
                end
            end
            // Long stall windows while the back-pressure job runs
            credit_seed = lcg_next(credit_seed);
            give = (valid_total > returned_total) && credit_seed[16]
                   && !(bp_hold && (cycle_cnt % 80) < 60);
            out_credit <= give;
            if (give) begin
                returned_total++;
            end
        end
    end

    task automatic check_idle_outputs();
        int err_before;
        err_before = errors;
        repeat (5) begin
            @(posedge ap_clk);
            checks++;
            if (in_credit || out_valid || done || busy) begin
                errors++;
                $display("At %0t ns outputs not idle after reset: in_credit=%b out_valid=%b",
                         $time, in_credit, out_valid);
                $display("    done=%b busy=%b", done, busy);
            end
        end
        report_test("reset", err_before);
    endtask

    // --------------------
    // Start a job, feed it under input credits and wait for done
    // --------------------
    task automatic run_job(input string name, input logic [ALU_OP_W-1:0] op_sel,
                           input logic [DEST_W-1:0] dest_sel, input int count,
                           input logic hold, input logic open_tail);
        int                err_before;
        int                credit_base;
        int                sent;
        int                seq_left;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [31:0]       r;
        logic              last;
        logic [DATA_W-1:0] run_sum;
        logic [2*DATA_W:0] expv;
        err_before = errors;
        sent       = 0;
        seq_left   = 0;
        run_sum    = '0;
        while (busy) begin
            @(posedge ap_clk);
        end
        credit_base = in_credit_seen;
        job_dest    = dest_sel;
        bp_hold   <= hold;
        start     <= 1'b1;
        cfg_op    <= op_sel;
        cfg_dest  <= dest_sel;
        cfg_count <= COUNT_W'(count);
        @(posedge ap_clk);
        start <= 1'b0;
        while (sent < count) begin
            if (sent_total - in_credit_seen < DEFAULT_IN_DEPTH) begin
                draw_random(a);
                draw_random(b);
                draw_random(r);
                if (op_sel == ALU_ACC) begin
                    if (seq_left == 0) begin
                        seq_left = int'(r[30:28]) % 5 + 1;
                    end
                    if (sent == count - 1) begin
                        // An open tail leaves a partial sum in the accumulator
                        last = !open_tail;
                    end else begin
                        last = (seq_left == 1);
                    end
                    seq_left = last ? 0 : seq_left - 1;
                end else begin
                    last = r[31];
                end
                expv = expected_result(op_sel, a, b, last, run_sum);
                if (op_sel == ALU_ACC) begin
                    run_sum = last ? '0 : expv[2*DATA_W-1:DATA_W];
                end
                if (expv[2*DATA_W]) begin
                    exp_q.push_back({expv[2*DATA_W-1:0], SEQ_W'(sent_total)});
                end
                in_valid <= 1'b1;
                in_a     <= a;
                in_b     <= b;
                in_seq   <= SEQ_W'(sent_total);
                in_last  <= last;
                sent++;
                sent_total++;
            end else begin
                in_valid <= 1'b0;
            end
            @(posedge ap_clk);
        end
        in_valid <= 1'b0;
        while (!done) begin
            @(posedge ap_clk);
        end
        checks += 2;
        if (exp_q.size() != 0) begin
            errors++;
            $display("At %0t ns done came with %0d outputs still missing", $time, exp_q.size());
        end
        if (in_credit_seen - credit_base != count) begin
            errors++;
            $display("Mismatch at %0t ns: in_credit pulses expected %0d, got %0d",
                     $time, count, in_credit_seen - credit_base);
        end
        @(posedge ap_clk);
        checks++;
        if (busy) begin
            errors++;
            $display("At %0t ns busy is still high the cycle after done", $time);
        end
        jobs_run++;
        report_test(name, err_before);
    endtask

    initial begin
        areset_generator = 1'b1;
        start      = 1'b0;
        cfg_op     = '0;
        cfg_dest   = '0;
        cfg_count  = '0;
        in_valid   = 1'b0;
        in_a       = '0;
        in_b       = '0;
        in_seq     = '0;
        in_last    = 1'b0;
        out_credit = 1'b0;
        repeat (10) @(posedge ap_clk);
        areset_generator <= 1'b0;
        check_idle_outputs();
        run_job("NOP", ALU_NOP, 4'h1, 20, 1'b0, 1'b0);
        run_job("ADD", ALU_ADD, 4'h2, 20, 1'b0, 1'b0);
        run_job("SUB", ALU_SUB, 4'h3, 20, 1'b0, 1'b0);
        run_job("MUL", ALU_MUL, 4'h4, 20, 1'b0, 1'b0);
        run_job("MAX", ALU_MAX, 4'h5, 20, 1'b0, 1'b0);
        run_job("ACC", ALU_ACC, 4'h6, 20, 1'b0, 1'b1);
        run_job("ACC second", ALU_ACC, 4'hA, 20, 1'b0, 1'b0);
        run_job("back-pressure", ALU_ADD, 4'hC, 30, 1'b1, 1'b0);
        checks++;
        if (done_seen != jobs_run) begin
            errors++;
            $display("Saw %0d done pulses for %0d jobs", done_seen, jobs_run);
        end
        $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

endmodule : alu_ops_tb

`default_nettype wire

// ==== all.f ====
+incdir+verif
hw/alu_ops_pkg.sv
hw/alu_ops_fifo.sv
hw/alu_ops_control.sv
hw/alu_ops_kernel.sv
hw/alu_ops_egress.sv
hw/alu_ops_top.sv
verif/alu_ops_tb.sv
